// File: rf_pg_64x19.f
source/rf_pkg.sv
source/rf_reset_sync.sv
source/rf_power_seq.sv
source/rf_array.sv
source/rf_read_stage.sv
source/rf_pg_64x19.sv
dv/rf_pg_64x19_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and decide the result from the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ns \
    --top-module rf_pg_64x19_tb -f rf_pg_64x19.f -o rf_sim \
    && ./obj_dir/rf_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "PASS: all tests" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: dv/rf_pg_64x19_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rf_pg_64x19_tb;

    localparam int wake_delay  = 4;
    localparam int ack_timeout = wake_delay + 10;
    localparam int n_rows      = 35;

    typedef enum logic [3:0] {
        op_idle, op_write, op_read, op_rdwr, op_pwr_off, op_pwr_on,
        op_isol_on, op_isol_off, op_ip_reset, op_scan_on, op_scan_off
    } op_t;

    // One table row, count repeats the operation over consecutive addresses or cycles
    typedef struct packed {
        op_t              op;
        rf_pkg::rf_addr_t addr;
        logic [6:0]       count;
        logic             rnd;
        rf_pkg::rf_data_t data;
    } step_t;

    logic             clk;
    logic             reset;
    logic             we;
    rf_pkg::rf_addr_t waddr;
    rf_pkg::rf_data_t wdata;
    logic             re;
    rf_pkg::rf_addr_t raddr;
    rf_pkg::rf_data_t rdata;
    logic             pgcb_isol_en;
    logic             pwr_enable_b_in;
    logic             pwr_enable_b_out;
    logic             ip_reset;
    logic             fscan_byprst_b;
    logic             fscan_rstbypen;

    step_t table_rows [n_rows];
    logic [31:0] rng_state;
    int data_errors;
    int level_errors;
    int count_errors;
    int timeout_errors;

    // Shadow of the array and of the read pipeline
    rf_pkg::rf_data_t         shadow [rf_pkg::depth];
    logic [rf_pkg::depth-1:0] shadow_written;
    rf_pkg::rf_data_t         m_row;
    logic                     m_strobe;
    rf_pkg::rf_data_t         m_rdata;
    logic                     m_powered;
    int                       wake_cnt;
    int                       mrst_cnt;

    rf_pg_64x19 #(
         .wake_delay       (wake_delay)
    ) dut (
         .wclk             (clk)
        ,.rclk             (clk)
        ,.reset            (reset)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.ip_reset         (ip_reset)
        ,.fscan_byprst_b   (fscan_byprst_b)
        ,.fscan_rstbypen   (fscan_rstbypen)
    );

    // Both ports run on this one clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic step_t make_row(input op_t op, input int addr, input int count,
                                       input int rnd, input int data);
        step_t r;
        r.op    = op;
        r.addr  = rf_pkg::rf_addr_t'(addr);
        r.count = 7'(count);
        r.rnd   = (rnd != 0);
        r.data  = rf_pkg::rf_data_t'(data);
        return r;
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic check_data(input string name, input rf_pkg::rf_data_t got,
                              input rf_pkg::rf_data_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("error %s: got 0x%05h expected 0x%05h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            level_errors++;
            $display("error %s: got 0x%0h expected 0x%0h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            count_errors++;
            $display("error %s: got 0x%0h expected 0x%0h at %0t ns", name, got, exp, $time);
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------

    // Advances the shadow by one edge, using the inputs that the edge has just sampled
    task automatic model_edge();
        logic mrst;
        logic acc;
        mrst = fscan_rstbypen ? ~fscan_byprst_b : (mrst_cnt != 0);
        acc  = m_powered & ~pgcb_isol_en & ~mrst;
        // The output register takes what the array presented one edge earlier
        if (reset || pgcb_isol_en) begin
            m_rdata = '0;
        end else if (m_strobe) begin
            m_rdata = m_row;
        end
        m_strobe = reset ? 1'b0 : (re & acc);
        // Read before write, so a colliding read sees the old word
        if (re && acc) begin
            m_row = shadow_written[raddr] ? shadow[raddr] : '0;
        end
        if (reset || !m_powered) begin
            shadow_written = '0;
        end else if (we && acc) begin
            shadow[waddr]         = wdata;
            shadow_written[waddr] = 1'b1;
        end
        // Power off is seen at once, power on only after wake_delay edges
        if (reset) begin
            m_powered = ~pwr_enable_b_in;
            wake_cnt  = 0;
        end else if (m_powered) begin
            if (pwr_enable_b_in) begin
                m_powered = 1'b0;
                wake_cnt  = 0;
            end
        end else if (pwr_enable_b_in) begin
            wake_cnt = 0;
        end else begin
            wake_cnt++;
            if (wake_cnt == wake_delay) begin
                m_powered = 1'b1;
            end
        end
        // Memory reset holds for two edges after ip_reset is released
        if (ip_reset) begin
            mrst_cnt = 2;
        end else if (mrst_cnt != 0) begin
            mrst_cnt--;
        end
    endtask

    // ------------------------------
    // Cycle stepping and waits
    // ------------------------------

    task automatic step();
        @(posedge clk);
        #1;
        model_edge();
        check_data("rdata", rdata, m_rdata);
        check_level("pwr_enable_b_out", pwr_enable_b_out, ~m_powered);
    endtask

    task automatic wait_ack(input logic target, input int exp_edges);
        int  edges;
        logic done;
        edges = 0;
        done  = 1'b0;
        while (!done && edges < ack_timeout) begin
            step();
            edges++;
            if (pwr_enable_b_out == target) begin
                done = 1'b1;
            end
        end
        if (done) begin
            check_count("pwr_enable_b_out edges", edges, exp_edges);
        end else begin
            timeout_errors++;
            $display("timeout: pwr_enable_b_out did not become %0b within %0d cycles",
                     target, ack_timeout);
        end
    endtask

    task automatic apply_row(input step_t row);
        int n;
        int i;
        n = int'(row.count);
        case (row.op)
            op_write: begin
                for (i = 0; i < n; i++) begin
                    we    = 1'b1;
                    waddr = rf_pkg::rf_addr_t'(int'(row.addr) + i);
                    if (row.rnd) begin
                        rng_state = xorshift32(rng_state);
                        wdata     = rng_state[rf_pkg::data_bits-1:0];
                    end else begin
                        wdata = row.data;
                    end
                    step();
                end
                we = 1'b0;
            end
            op_read: begin
                // Back to back reads, the model checks each one two edges later
                for (i = 0; i < n; i++) begin
                    re    = 1'b1;
                    raddr = rf_pkg::rf_addr_t'(int'(row.addr) + i);
                    step();
                end
                re = 1'b0;
            end
            op_rdwr: begin
                we    = 1'b1;
                re    = 1'b1;
                waddr = row.addr;
                raddr = row.addr;
                wdata = row.data;
                step();
                we = 1'b0;
                re = 1'b0;
            end
            op_pwr_off: begin
                pwr_enable_b_in = 1'b1;
                wait_ack(1'b1, 1);
            end
            op_pwr_on: begin
                pwr_enable_b_in = 1'b0;
                wait_ack(1'b0, wake_delay);
            end
            op_isol_on: begin
                pgcb_isol_en = 1'b1;
                repeat (n) step();
            end
            op_isol_off: begin
                pgcb_isol_en = 1'b0;
                step();
            end
            op_ip_reset: begin
                ip_reset = 1'b1;
                step();
                ip_reset = 1'b0;
            end
            op_scan_on: begin
                // The write in this same cycle must already be blocked
                fscan_rstbypen = 1'b1;
                fscan_byprst_b = 1'b0;
                we             = 1'b1;
                waddr          = row.addr;
                wdata          = row.data;
                step();
                we = 1'b0;
            end
            op_scan_off: begin
                fscan_rstbypen = 1'b0;
                fscan_byprst_b = 1'b1;
                step();
            end
            default: begin
                repeat (n) step();
            end
        endcase
    endtask

    // ------------------------------
    // Stimulus table
    // ------------------------------

    task automatic fill_table();
        table_rows[0]  = make_row(op_idle,     0,  3,  0, 0);
        // Unwritten words and same cycle collisions
        table_rows[1]  = make_row(op_read,     0,  4,  0, 0);
        table_rows[2]  = make_row(op_write,    5,  1,  0, 'h12345);
        table_rows[3]  = make_row(op_rdwr,     5,  1,  0, 'h7abcd);
        table_rows[4]  = make_row(op_read,     5,  1,  0, 0);
        table_rows[5]  = make_row(op_rdwr,     9,  1,  0, 'h00f0f);
        table_rows[6]  = make_row(op_idle,     0,  2,  0, 0);
        // Fill every word with random data and read it all back
        table_rows[7]  = make_row(op_write,    0,  64, 1, 0);
        table_rows[8]  = make_row(op_read,     0,  64, 0, 0);
        table_rows[9]  = make_row(op_idle,     0,  3,  0, 0);
        // Isolation clamps rdata and drops both ports
        table_rows[10] = make_row(op_isol_on,  0,  3,  0, 0);
        table_rows[11] = make_row(op_write,    10, 1,  0, 'h55555);
        table_rows[12] = make_row(op_read,     10, 1,  0, 0);
        table_rows[13] = make_row(op_isol_off, 0,  1,  0, 0);
        table_rows[14] = make_row(op_idle,     0,  2,  0, 0);
        table_rows[15] = make_row(op_read,     8,  4,  0, 0);
        table_rows[16] = make_row(op_idle,     0,  3,  0, 0);
        // Memory reset through the synchronizer and through the scan bypass
        table_rows[17] = make_row(op_ip_reset, 0,  1,  0, 0);
        table_rows[18] = make_row(op_write,    20, 1,  0, 'h2aaaa);
        table_rows[19] = make_row(op_read,     21, 1,  0, 0);
        // Third cycle after the pulse, the array is open again
        table_rows[20] = make_row(op_read,     21, 1,  0, 0);
        table_rows[21] = make_row(op_read,     20, 2,  0, 0);
        table_rows[22] = make_row(op_scan_on,  22, 1,  0, 'h3c3c3);
        table_rows[23] = make_row(op_read,     22, 1,  0, 0);
        table_rows[24] = make_row(op_scan_off, 0,  1,  0, 0);
        table_rows[25] = make_row(op_read,     22, 1,  0, 0);
        table_rows[26] = make_row(op_idle,     0,  3,  0, 0);
        // Power down loses every word, writes while off go nowhere
        table_rows[27] = make_row(op_pwr_off,  0,  1,  0, 0);
        table_rows[28] = make_row(op_write,    3,  1,  0, 'h11111);
        table_rows[29] = make_row(op_read,     3,  1,  0, 0);
        table_rows[30] = make_row(op_pwr_on,   0,  1,  0, 0);
        table_rows[31] = make_row(op_read,     0,  64, 0, 0);
        table_rows[32] = make_row(op_write,    7,  1,  0, 'h6789a);
        table_rows[33] = make_row(op_read,     7,  1,  0, 0);
        table_rows[34] = make_row(op_idle,     0,  3,  0, 0);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        reset           = 1'b1;
        ip_reset        = 1'b1;
        we              = 1'b0;
        waddr           = '0;
        wdata           = '0;
        re              = 1'b0;
        raddr           = '0;
        pgcb_isol_en    = 1'b0;
        pwr_enable_b_in = 1'b0;
        fscan_byprst_b  = 1'b1;
        fscan_rstbypen  = 1'b0;
        rng_state       = 32'd96978;
        data_errors     = 0;
        level_errors    = 0;
        count_errors    = 0;
        timeout_errors  = 0;
        shadow_written  = '0;
        m_row           = '0;
        m_strobe        = 1'b0;
        m_rdata         = '0;
        m_powered       = 1'b1;
        wake_cnt        = 0;
        mrst_cnt        = 2;
        fill_table();
        // The memory reset is pulsed together with the main reset so the synchronizer starts known
        repeat (4) step();
        reset    = 1'b0;
        ip_reset = 1'b0;
        for (int k = 0; k < n_rows; k++) begin
            apply_row(table_rows[k]);
        end
        $display("errors: data %0d, level %0d, count %0d, timeout %0d",
                 data_errors, level_errors, count_errors, timeout_errors);
        if (data_errors + level_errors + count_errors + timeout_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/rf_pg_64x19.sv
`timescale 1ns/1ns
`default_nettype none

module rf_pg_64x19 #(
     parameter int wake_delay = 4
) (
     input  logic             wclk
    ,input  logic             rclk
    ,input  logic             reset

    // Write port
    ,input  logic             we
    ,input  rf_pkg::rf_addr_t waddr
    ,input  rf_pkg::rf_data_t wdata

    // Read port
    ,input  logic             re
    ,input  rf_pkg::rf_addr_t raddr
    ,output rf_pkg::rf_data_t rdata

    // Power management
    ,input  logic             pgcb_isol_en
    ,input  logic             pwr_enable_b_in
    ,output logic             pwr_enable_b_out

    // Memory reset and scan control
    ,input  logic             ip_reset
    ,input  logic             fscan_byprst_b
    ,input  logic             fscan_rstbypen
);

    rf_pkg::rf_wr_req_t wr_req;
    rf_pkg::rf_rd_req_t rd_req;
    rf_pkg::rf_row_t    rd_row;
    logic               rd_strobe;
    logic               mem_reset;
    logic               powered;
    logic               accessible;

    // ------------------------------
    // Request packing
    // ------------------------------

    // The physical row is one bit wider, the pad is always written as zero
    assign wr_req.en       = we;
    assign wr_req.addr     = waddr;
    assign wr_req.data.pad = '0;
    assign wr_req.data.data = wdata;

    assign rd_req.en   = re;
    assign rd_req.addr = raddr;

    // ------------------------------
    // Reset and power control
    // ------------------------------

    rf_reset_sync i_reset_sync (
         .rclk             (rclk)
        ,.ip_reset         (ip_reset)
        ,.fscan_rstbypen   (fscan_rstbypen)
        ,.fscan_byprst_b   (fscan_byprst_b)
        ,.mem_reset        (mem_reset)
    );

    rf_power_seq #(
         .wake_delay       (wake_delay)
    ) i_power_seq (
         .rclk             (rclk)
        ,.reset            (reset)
        ,.mem_reset        (mem_reset)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.powered          (powered)
        ,.accessible       (accessible)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // ------------------------------
    // Storage and read pipeline
    // ------------------------------

    rf_array i_array (
         .wclk             (wclk)
        ,.rclk             (rclk)
        ,.reset            (reset)
        ,.powered          (powered)
        ,.accessible       (accessible)
        ,.wr_req           (wr_req)
        ,.rd_req           (rd_req)
        ,.rd_row           (rd_row)
        ,.rd_strobe        (rd_strobe)
    );

    // Second read register, trims the row back to the user width
    rf_read_stage i_read_stage (
         .rclk             (rclk)
        ,.reset            (reset)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.rd_row           (rd_row)
        ,.rd_strobe        (rd_strobe)
        ,.rdata            (rdata)
    );

endmodule

`default_nettype wire

// File: source/rf_read_stage.sv
`timescale 1ns/1ns
`default_nettype none

module rf_read_stage (
     input  logic             rclk
    ,input  logic             reset
    ,input  logic             pgcb_isol_en
    ,input  rf_pkg::rf_row_t  rd_row
    ,input  logic             rd_strobe
    ,output rf_pkg::rf_data_t rdata
);

    // ------------------------------
    // Output register
    // ------------------------------

    // The register also acts as the isolation clamp, so rdata goes to zero
    // at the first edge that sees pgcb_isol_en high
    always_ff @(posedge rclk) begin
        if (reset || pgcb_isol_en) begin
            rdata <= '0;
        end else if (rd_strobe) begin
            // Pad bit of the physical row is dropped here
            rdata <= rd_row.data;
        end
    end

    // Without a strobe the last read value is held

endmodule

`default_nettype wire

// File: source/rf_array.sv
`timescale 1ns/1ns
`default_nettype none

module rf_array (
     input  logic               wclk
    ,input  logic               rclk
    ,input  logic               reset
    ,input  logic               powered
    ,input  logic               accessible
    ,input  rf_pkg::rf_wr_req_t wr_req
    ,input  rf_pkg::rf_rd_req_t rd_req
    ,output rf_pkg::rf_row_t    rd_row
    ,output logic               rd_strobe
);

    // Storage rows, contents are only meaningful where the written flag is set
    rf_pkg::rf_row_t mem [rf_pkg::depth];

    // One flag per word, set by a write and lost with power
    logic [rf_pkg::depth-1:0] written;

    logic wr_ok;
    logic rd_ok;

    // Accesses outside the accessible window are simply dropped
    assign wr_ok = wr_req.en & accessible;
    assign rd_ok = rd_req.en & accessible;

    // ------------------------------
    // Write side
    // ------------------------------

    always_ff @(posedge wclk) begin
        if (wr_ok) begin
            mem[wr_req.addr] <= wr_req.data;
        end
    end

    // Power loss turns every word back into an unwritten one
    always_ff @(posedge wclk) begin
        if (reset || !powered) begin
            written <= '0;
        end else if (wr_ok) begin
            written[wr_req.addr] <= 1'b1;
        end
    end

    // ------------------------------
    // Read side
    // ------------------------------

    // The strobe tells the output stage that a new row is on rd_row
    always_ff @(posedge rclk) begin
        if (reset) begin
            rd_strobe <= 1'b0;
        end else begin
            rd_strobe <= rd_ok;
        end
    end

    // Sampled before the write of the same edge lands, so a colliding read gets old data
    always_ff @(posedge rclk) begin
        if (rd_ok) begin
            if (written[rd_req.addr]) begin
                rd_row <= mem[rd_req.addr];
            end else begin
                rd_row <= '0;  // never written since reset or power up
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rf_power_seq.sv
`timescale 1ns/1ns
`default_nettype none

module rf_power_seq #(
     parameter int wake_delay = 4
) (
     input  logic rclk
    ,input  logic reset
    ,input  logic mem_reset
    ,input  logic pwr_enable_b_in
    ,input  logic pgcb_isol_en
    ,output logic powered
    ,output logic accessible
    ,output logic pwr_enable_b_out
);

    // The counter only has to reach wake_delay - 1
    localparam int cnt_bits = (wake_delay > 1) ? $clog2(wake_delay) : 1;

    // Last count value before the array is declared awake
    localparam logic [cnt_bits-1:0] wake_last = cnt_bits'(wake_delay - 1);

    // Off and waking share one state, the counter just stays at zero while power is off
    typedef enum logic [0:0] {
        seq_on,
        seq_waking
    } seq_state_t;

    seq_state_t          state;
    seq_state_t          state_nxt;
    logic [cnt_bits-1:0] wake_cnt;
    logic [cnt_bits-1:0] wake_cnt_nxt;

    // ------------------------------
    // Next state
    // ------------------------------

    always_comb begin
        state_nxt    = state;
        wake_cnt_nxt = '0;
        case (state)
            seq_on: begin
                // A power off request takes effect at the very next edge
                if (pwr_enable_b_in) begin
                    state_nxt = seq_waking;
                end
            end
            seq_waking: begin
                if (pwr_enable_b_in) begin
                    // Still held off, so the wake count restarts from zero
                    wake_cnt_nxt = '0;
                end else if (wake_cnt == wake_last) begin
                    state_nxt = seq_on;
                end else begin
                    wake_cnt_nxt = wake_cnt + 1'b1;
                end
            end
            default: begin
                state_nxt = seq_waking;
            end
        endcase
    end

    // ------------------------------
    // State registers
    // ------------------------------

    always_ff @(posedge rclk) begin
        if (reset) begin
            // Come out of reset powered unless power off is already requested
            state    <= pwr_enable_b_in ? seq_waking : seq_on;
            wake_cnt <= '0;
        end else begin
            state    <= state_nxt;
            wake_cnt <= wake_cnt_nxt;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    assign powered = (state == seq_on);

    // The acknowledge mirrors the powered level, low means the array is up
    assign pwr_enable_b_out = ~powered;

    // One level for the datapath: powered, not isolated and out of memory reset
    assign accessible = powered & ~pgcb_isol_en & ~mem_reset;

endmodule

`default_nettype wire

// File: source/rf_reset_sync.sv
`timescale 1ns/1ns
`default_nettype none

module rf_reset_sync (
     input  logic rclk
    ,input  logic ip_reset
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b
    ,output logic mem_reset
);

    // Two stage shift register of the memory reset
    // Both stages load at once, so the reset is seen one edge after ip_reset is sampled
    logic [1:0] sync_q;

    // ------------------------------
    // Synchronizer flops
    // ------------------------------

    always_ff @(posedge rclk) begin
        if (ip_reset) begin
            sync_q <= 2'b11;
        end else begin
            // Release ripples through both stages, two edges after ip_reset drops
            sync_q <= {sync_q[0], 1'b0};
        end
    end

    // ------------------------------
    // Scan bypass
    // ------------------------------

    // In scan mode the reset comes straight from the tester pin, which is active low
    assign mem_reset = fscan_rstbypen ? ~fscan_byprst_b : sync_q[1];

endmodule

`default_nettype wire

// File: source/rf_pkg.sv
`default_nettype none

package rf_pkg;

    // ------------------------------
    // Geometry of the register file
    // ------------------------------

    // Address width for 64 words
    localparam int addr_bits = 6;

    // Width of the word seen by the user of the wrapper
    localparam int data_bits = 19;

    // Width of one physical row, one bit wider than the user word
    localparam int row_bits = 20;

    // Number of words in the array
    localparam int depth = 64;

    // ------------------------------
    // Basic types
    // ------------------------------

    typedef logic [addr_bits-1:0] rf_addr_t;

    typedef logic [data_bits-1:0] rf_data_t;

    // Physical row, the pad sits above the user word and is always written as zero
    typedef struct packed {
        logic [row_bits-data_bits-1:0] pad;
        rf_data_t                      data;
    } rf_row_t;

    // ------------------------------
    // Request structs
    // ------------------------------

    // Write request as seen by the array, 27 bits
    typedef struct packed {
        logic     en;
        rf_addr_t addr;
        rf_row_t  data;
    } rf_wr_req_t;

    // Read request as seen by the array, 7 bits
    typedef struct packed {
        logic     en;
        rf_addr_t addr;
    } rf_rd_req_t;

endpackage

`default_nettype wire
